/* src/mul_cfg.svh */
// Multiplier width configuration
// Operand, byte, partial product, product and lookahead group sizes

`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// Operand and byte split
`define MUL_OPND_W 16
`define MUL_HALF_W 8

// Byte product and full product
`define MUL_PART_W 16
`define MUL_PROD_W 32

// Lookahead adder grouping, 8 groups of 4 bits
`define MUL_GRP_W 4
`define MUL_NUM_GRP 8

`endif

/* src/mul_pkg.sv */
// Multiplier shared types
// Data words of the 16x16 multiplier and the handshake state

`include "mul_cfg.svh"

package mul_pkg;

  // Full operand as seen on the handshake port
  typedef logic [`MUL_OPND_W-1:0] operand_t;

  // One byte of an operand
  typedef logic [`MUL_HALF_W-1:0] half_t;

  // Exact product of two bytes
  typedef logic [`MUL_PART_W-1:0] part_prod_t;

  // Full product, also the adder word
  typedef logic [`MUL_PROD_W-1:0] product_t;

  // Four-phase handshake
  // LOAD is the single cycle where the core output settles
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    DONE
  } hs_state_t;

endpackage

/* src/array_mult8.sv */
// Exact 8x8 unsigned array multiplier
// Carry-save rows of full and half adders over the AND plane,
// closed by a ripple row for the upper byte

`include "mul_cfg.svh"

module array_mult8 import mul_pkg::*; (
  input  half_t      x,
  input  half_t      y,
  output part_prod_t prod
);

  logic [`MUL_HALF_W-1:0] pp  [`MUL_HALF_W];
  logic [`MUL_HALF_W-1:0] s_r [`MUL_HALF_W];
  logic [`MUL_HALF_W-1:0] c_r [`MUL_HALF_W];
  logic [`MUL_HALF_W-2:0] rc;

  genvar r, j, k;

  // AND plane, row r is x weighted by y[r]
  for (r = 0; r < `MUL_HALF_W; r++) begin : g_and
    assign pp[r] = x & {`MUL_HALF_W{y[r]}};
  end

  // First row enters the array with no carries
  assign s_r[0] = pp[0];
  assign c_r[0] = '0;

  for (r = 1; r < `MUL_HALF_W; r++) begin : g_row
    for (j = 0; j < `MUL_HALF_W; j++) begin : g_col
      if (j == `MUL_HALF_W - 1) begin : g_ha
        // Top column has no sum coming down from the row above
        assign s_r[r][j] = pp[r][j] ^ c_r[r-1][j];
        assign c_r[r][j] = pp[r][j] & c_r[r-1][j];
      end else begin : g_fa
        assign s_r[r][j] = pp[r][j] ^ s_r[r-1][j+1] ^ c_r[r-1][j];
        assign c_r[r][j] = (pp[r][j] & s_r[r-1][j+1]) |
                           (pp[r][j] & c_r[r-1][j]) |
                           (s_r[r-1][j+1] & c_r[r-1][j]);
      end
    end
  end

  // Lower byte drops out of the rightmost column of each row
  for (r = 0; r < `MUL_HALF_W; r++) begin : g_low
    assign prod[r] = s_r[r][0];
  end

  // Ripple row merges the last sums and carries
  assign prod[`MUL_HALF_W] = s_r[`MUL_HALF_W-1][1] ^ c_r[`MUL_HALF_W-1][0];
  assign rc[0]             = s_r[`MUL_HALF_W-1][1] & c_r[`MUL_HALF_W-1][0];

  for (k = 1; k < `MUL_HALF_W - 1; k++) begin : g_rip
    assign prod[`MUL_HALF_W+k] = s_r[`MUL_HALF_W-1][k+1] ^ c_r[`MUL_HALF_W-1][k] ^ rc[k-1];
    assign rc[k] = (s_r[`MUL_HALF_W-1][k+1] & c_r[`MUL_HALF_W-1][k]) |
                   (s_r[`MUL_HALF_W-1][k+1] & rc[k-1]) |
                   (c_r[`MUL_HALF_W-1][k] & rc[k-1]);
  end

  // Top bit, an 8x8 product never carries past 16 bits
  assign prod[`MUL_PART_W-1] = c_r[`MUL_HALF_W-1][`MUL_HALF_W-1] ^ rc[`MUL_HALF_W-2];

endmodule

/* src/cla_group4.sv */
// 4-bit carry-lookahead group
// Forms the internal carries from bit propagate/generate and the
// group carry-in, then the sum bits

`include "mul_cfg.svh"

module cla_group4 (
  input  logic [`MUL_GRP_W-1:0] prop,
  input  logic [`MUL_GRP_W-1:0] gen,
  input  logic                  cin,
  output logic [`MUL_GRP_W-1:0] sum
);

  logic [`MUL_GRP_W-1:0] c;

  // Carry into each bit of the group
  // gen[3] would only feed the group carry-out, which the
  // second lookahead level in the adder handles
  assign c[0] = cin;
  assign c[1] = gen[0] | (prop[0] & cin);
  assign c[2] = gen[1] | (prop[1] & gen[0]) | (prop[1] & prop[0] & cin);
  assign c[3] = gen[2] | (prop[2] & gen[1]) | (prop[2] & prop[1] & gen[0]) |
                (prop[2] & prop[1] & prop[0] & cin);

  assign sum = prop ^ c;

endmodule

/* src/cla_adder32.sv */
// 32-bit two-level carry-lookahead adder
// Bit P/G, group P/G per 4-bit group, then a flat lookahead
// for every group carry. Carry-in is zero, carry-out not formed

`include "mul_cfg.svh"

module cla_adder32 import mul_pkg::*; (
  input  product_t x,
  input  product_t y,
  output product_t sum
);

  product_t p;
  product_t g;

  // Top group only produces sum bits, so no group P/G for it
  logic [`MUL_NUM_GRP-2:0] grp_p;
  logic [`MUL_NUM_GRP-2:0] grp_g;
  logic [`MUL_NUM_GRP-1:0] grp_c;

  genvar k;

  assign p = x ^ y;
  assign g = x & y;

  for (k = 0; k < `MUL_NUM_GRP - 1; k++) begin : g_pg
    assign grp_p[k] = &p[k*`MUL_GRP_W +: `MUL_GRP_W];
    assign grp_g[k] = g[k*`MUL_GRP_W+3] |
                      (p[k*`MUL_GRP_W+3] & g[k*`MUL_GRP_W+2]) |
                      (p[k*`MUL_GRP_W+3] & p[k*`MUL_GRP_W+2] & g[k*`MUL_GRP_W+1]) |
                      (p[k*`MUL_GRP_W+3] & p[k*`MUL_GRP_W+2] &
                       p[k*`MUL_GRP_W+1] & g[k*`MUL_GRP_W]);
  end

  // Second level lookahead
  // carry into group n is any lower group generating and
  // every group between it and n propagating
  always_comb begin
    logic term;
    grp_c = '0;
    for (int n = 1; n < `MUL_NUM_GRP; n++) begin
      for (int m = 0; m < n; m++) begin
        term = grp_g[m];
        for (int q = m + 1; q < n; q++) begin
          term = term & grp_p[q];
        end
        grp_c[n] = grp_c[n] | term;
      end
    end
  end

  for (k = 0; k < `MUL_NUM_GRP; k++) begin : g_grp
    cla_group4 u_grp (
      .prop (p[k*`MUL_GRP_W +: `MUL_GRP_W]),
      .gen  (g[k*`MUL_GRP_W +: `MUL_GRP_W]),
      .cin  (grp_c[k]),
      .sum  (sum[k*`MUL_GRP_W +: `MUL_GRP_W])
    );
  end

endmodule

/* src/mul16_compose.sv */
// 16x16 unsigned multiplier core
// Four byte products, aligned and summed by two lookahead adders

`include "mul_cfg.svh"

module mul16_compose import mul_pkg::*; (
  input  operand_t a,
  input  operand_t b,
  output product_t sum
);

  half_t      a_lo, a_hi, b_lo, b_hi;
  part_prod_t ll, hl, lh, hh;
  product_t   word_hhll;
  product_t   shift_lh;
  product_t   shift_hl;
  product_t   sum_mid;

  assign a_lo = a[`MUL_HALF_W-1:0];
  assign a_hi = a[`MUL_OPND_W-1:`MUL_HALF_W];
  assign b_lo = b[`MUL_HALF_W-1:0];
  assign b_hi = b[`MUL_OPND_W-1:`MUL_HALF_W];

  array_mult8 u_lxl (.x(a_lo), .y(b_lo), .prod(ll));
  array_mult8 u_hxl (.x(a_hi), .y(b_lo), .prod(hl));
  array_mult8 u_lxh (.x(a_lo), .y(b_hi), .prod(lh));
  array_mult8 u_hxh (.x(a_hi), .y(b_hi), .prod(hh));

  // Low and high products do not overlap
  assign word_hhll = {hh, ll};

  // Cross products sit one byte up
  assign shift_lh = {{`MUL_HALF_W{1'b0}}, lh, {`MUL_HALF_W{1'b0}}};
  assign shift_hl = {{`MUL_HALF_W{1'b0}}, hl, {`MUL_HALF_W{1'b0}}};

  cla_adder32 u_add_lh (.x(word_hhll), .y(shift_lh), .sum(sum_mid));
  cla_adder32 u_add_hl (.x(sum_mid),   .y(shift_hl), .sum(sum));

endmodule

/* src/mul_req_ack_ctrl.sv */
// Four-phase req/ack controller
// Captures operands on request, registers the core result one
// cycle later and holds it with ack until req drops

module mul_req_ack_ctrl import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req,
  input  operand_t a,
  input  operand_t b,
  input  product_t sum,
  output operand_t a_q,
  output operand_t b_q,
  output logic     ack,
  output product_t p
);

  hs_state_t state;
  logic      capture;

  assign capture = (state == IDLE) && req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      ack   <= 1'b0;
      p     <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= LOAD;
          end
        end
        // Core output from a_q/b_q is valid here
        LOAD: begin
          state <= DONE;
          ack   <= 1'b1;
          p     <= sum;
        end
        // Hold ack and p until the requester lets go
        DONE: begin
          if (!req) begin
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // Operand registers feeding the core
  always_ff @(posedge clk) begin
    if (capture) begin
      a_q <= a;
      b_q <= b;
    end
  end

  a_ack_from_load: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(state) == LOAD);

  a_p_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && $past(ack)) |-> $stable(p));

  a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && $fell(req)) |=> !ack);

endmodule

/* src/mul16_top.sv */
// 16x16 multiplier with four-phase req/ack handshake
// Controller registers operands and product around the core

module mul16_top import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req,
  input  operand_t a,
  input  operand_t b,
  output logic     ack,
  output product_t p
);

  operand_t a_q;
  operand_t b_q;
  product_t core_sum;

  mul_req_ack_ctrl u_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .a     (a),
    .b     (b),
    .sum   (core_sum),
    .a_q   (a_q),
    .b_q   (b_q),
    .ack   (ack),
    .p     (p)
  );

  mul16_compose u_core (
    .a   (a_q),
    .b   (b_q),
    .sum (core_sum)
  );

endmodule

/* tests/tb_mul16.sv */
// Testbench for the 16x16 multiplier with req/ack handshake
// Runs cases from the stimulus file, random pairs and a held request,
// checking products and ack timing

module tb_mul16 import mul_pkg::*; ();

  localparam int DRIVE_DLY   = 5;
  localparam int WAIT_LIMIT  = 20;
  localparam int NUM_RANDOM  = 200;
  localparam int HOLD_CYCLES = 10;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     req;
  operand_t a;
  operand_t b;
  logic     ack;
  product_t p;

  int       checks;
  int       mismatches;
  int       failures;
  logic     aborted;
  integer   seed;

  always #50 clk = ~clk;

  mul16_top dut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .a     (a),
    .b     (b),
    .ack   (ack),
    .p     (p)
  );

  task automatic finish_run();
    $display("Checks run: %0d, value mismatches: %0d, other failures: %0d",
             checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic abort_run(input string what);
    report_failure(what);
    aborted = 1'b1;
  endtask

  task automatic check_product(input string name, input product_t got, input product_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("FAIL time=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ack(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("FAIL time=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Inputs change and outputs are sampled a little after the edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Drop req and expect ack to fall at the next edge
  task automatic release_req();
    int n;
    req = 1'b0;
    n = 0;
    while (ack !== 1'b0 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (ack !== 1'b0) begin
      abort_run("ack stayed high after req fell");
    end else if (n != 1) begin
      report_failure($sformatf("ack fell %0d cycles after req fell instead of 1", n));
    end
  endtask

  // Full handshake, ack is seen two edges after req is driven
  task automatic run_case(input operand_t op_a, input operand_t op_b, input product_t exp);
    int n;
    a = op_a;
    b = op_b;
    req = 1'b1;
    n = 0;
    while (ack !== 1'b1 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (ack !== 1'b1) begin
      abort_run($sformatf("No ack for a=%h b=%h within %0d cycles", op_a, op_b, WAIT_LIMIT));
    end else begin
      if (n != 2) begin
        report_failure($sformatf("ack rose %0d cycles after req instead of 2", n));
      end
      check_product("p", p, exp);
      release_req();
    end
  endtask

  // Keep req high and change operands while ack is up
  task automatic hold_case(input operand_t op_a, input operand_t op_b,
                           input operand_t new_a, input operand_t new_b);
    product_t exp0;
    int       n;
    exp0 = product_t'(op_a) * product_t'(op_b);
    a = op_a;
    b = op_b;
    req = 1'b1;
    n = 0;
    while (ack !== 1'b1 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (ack !== 1'b1) begin
      abort_run("No ack for the held request");
    end else begin
      check_product("p", p, exp0);
      a = new_a;
      b = new_b;
      for (int k = 0; k < HOLD_CYCLES; k++) begin
        next_cycle();
        check_ack("ack", ack, 1'b1);
        check_product("p", p, exp0);
      end
      release_req();
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int          n_file;
    string       line;
    operand_t    fa;
    operand_t    fb;
    product_t    fe;
    logic [31:0] rnd;
    operand_t    na;
    operand_t    nb;
    rst_n = 1'b0;
    req = 1'b0;
    a = '0;
    b = '0;
    checks = 0;
    mismatches = 0;
    failures = 0;
    aborted = 1'b0;
    n_file = 0;
    na = '0;
    nb = '0;
    seed = 32'h7b94;
    repeat (3) @(posedge clk);
    #DRIVE_DLY rst_n = 1'b1;

    // Idle outputs after reset
    check_ack("ack", ack, 1'b0);
    check_product("p", p, '0);
    next_cycle();
    check_ack("ack", ack, 1'b0);
    check_product("p", p, '0);

    fd = $fopen("tests/mul16_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open tests/mul16_stimulus.txt");
    end else begin
      while (!$feof(fd) && !aborted) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 0 && line[0] != "#") begin
          code = $sscanf(line, "%h %h %h", fa, fb, fe);
          if (code == 3) begin
            run_case(fa, fb, fe);
            n_file++;
          end
        end
      end
      $fclose(fd);
      if (n_file == 0) begin
        report_failure("No cases were read from the stimulus file");
      end

      for (int i = 0; i < NUM_RANDOM && !aborted; i++) begin
        rnd = $random(seed);
        run_case(rnd[15:0], rnd[31:16],
                 product_t'(rnd[15:0]) * product_t'(rnd[31:16]));
      end

      // New operands during the hold must not leak into p
      if (!aborted) begin
        rnd = $random(seed);
        na = rnd[15:0];
        nb = rnd[31:16];
        hold_case(16'hBEEF, 16'h1357, na, nb);
      end
      if (!aborted) begin
        run_case(na, nb, product_t'(na) * product_t'(nb));
      end
    end

    finish_run();
  end

endmodule

/* build.f */
+incdir+src
src/mul_pkg.sv
src/array_mult8.sv
src/cla_group4.sv
src/cla_adder32.sv
src/mul16_compose.sv
src/mul_req_ack_ctrl.sv
src/mul16_top.sv
tests/tb_mul16.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_mul16 \
		--Mdir obj_dir -o tb_mul16
	./obj_dir/tb_mul16 | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/mul16_stimulus.txt */
# Columns: operand a, operand b, expected product (hex)
# Lines starting with # are skipped
0000 0000 00000000
0001 0001 00000001
0000 FFFF 00000000
FFFF 0001 0000FFFF
0001 FFFF 0000FFFF
FFFF FFFF FFFE0001
00FF 00FF 0000FE01
FF00 FF00 FE010000
00FF FF00 00FE0100
FF00 00FF 00FE0100
0080 0080 00004000
8000 8000 40000000
8000 0002 00010000
0002 8000 00010000
1234 0001 00001234
0100 0100 00010000
0101 0101 00010201
FFFF 0100 00FFFF00
00FF 0101 0000FFFF
7FFF 7FFF 3FFF0001
8001 8001 40010001
AAAA 5555 38E31C72
5555 5555 1C718E39
AAAA AAAA 71C638E4
00FF 0001 000000FF
0F0F F0F0 0E2C2E10
00F0 000F 00000E10
1234 5678 06260060
FFFF 8000 7FFF8000
01FF 01FF 0003FC01
FF01 FF01 FE02FE01
00FF FFFF 00FEFF01
